//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] xlen_t;                   // Data word
    typedef logic [4:0]  reg_idx_t;                // Register index

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;                      // Also B-type imm[12|10:5]
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;                       // Also B-type imm[4:1|11]
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic        imm_20;
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } j_fmt_t;

    // One instruction word seen through each encoding format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef logic [2:0] instr_type_t;
    localparam instr_type_t I_TYPE   = 3'd0;
    localparam instr_type_t B_TYPE   = 3'd1;
    localparam instr_type_t S_TYPE   = 3'd2;
    localparam instr_type_t U_TYPE   = 3'd3;
    localparam instr_type_t J_TYPE   = 3'd4;
    localparam instr_type_t R_TYPE   = 3'd6;
    localparam instr_type_t BAD_TYPE = 3'd7;       // Opcode not executed here

    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JAL   = 7'b1101111;
    localparam logic [6:0] OP_JALR  = 7'b1100111;

    typedef logic [1:0] src_a_t;                   // Operand A mux select
    localparam src_a_t A_RS1     = 2'd0;
    localparam src_a_t A_FWD_EXE = 2'd1;
    localparam src_a_t A_PC      = 2'd2;
    localparam src_a_t A_FWD_MEM = 2'd3;

    typedef logic [2:0] src_b_t;                   // Operand B mux select
    localparam src_b_t B_RS2     = 3'd0;
    localparam src_b_t B_FWD_EXE = 3'd1;
    localparam src_b_t B_IMM     = 3'd2;
    localparam src_b_t B_FOUR    = 3'd3;
    localparam src_b_t B_FWD_MEM = 3'd4;

    typedef logic [3:0] alu_op_t;
    localparam alu_op_t ADD    = 4'd0;
    localparam alu_op_t SUB    = 4'd1;
    localparam alu_op_t SLL    = 4'd2;
    localparam alu_op_t SLT    = 4'd3;
    localparam alu_op_t SLTU   = 4'd4;
    localparam alu_op_t XOR    = 4'd5;
    localparam alu_op_t SRL    = 4'd6;
    localparam alu_op_t SRA    = 4'd7;
    localparam alu_op_t OR     = 4'd8;
    localparam alu_op_t AND    = 4'd9;
    localparam alu_op_t PASS_B = 4'd10;            // LUI result is the immediate

endpackage

`default_nettype wire

//--- hdl/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
    input  wire rv_pkg::instr_u       instr,
    output logic [6:0]                opcode,
    output logic [2:0]                funct3,
    output logic [6:0]                funct7,
    output rv_pkg::reg_idx_t          rs1,
    output rv_pkg::reg_idx_t          rs2,
    output rv_pkg::reg_idx_t          rd,
    output rv_pkg::instr_type_t       instruction_type,
    output rv_pkg::xlen_t             imm
);

    assign opcode = instr.r_fmt.opcode;            // Fixed fields share R-type positions
    assign funct3 = instr.r_fmt.funct3;
    assign funct7 = instr.r_fmt.funct7;
    assign rs1    = instr.r_fmt.rs1;
    assign rs2    = instr.r_fmt.rs2;
    assign rd     = instr.r_fmt.rd;

    always_comb begin
        case (opcode)
            rv_pkg::OP_IMM:   instruction_type = rv_pkg::I_TYPE;
            rv_pkg::OP_JALR:  instruction_type = rv_pkg::I_TYPE;
            rv_pkg::OP_REG:   instruction_type = rv_pkg::R_TYPE;
            rv_pkg::OP_LUI:   instruction_type = rv_pkg::U_TYPE;
            rv_pkg::OP_AUIPC: instruction_type = rv_pkg::U_TYPE;
            rv_pkg::OP_JAL:   instruction_type = rv_pkg::J_TYPE;
            default:          instruction_type = rv_pkg::BAD_TYPE; // Passes as a bubble
        endcase
    end

    always_comb begin
        case (instruction_type)
            rv_pkg::I_TYPE: imm = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
            rv_pkg::S_TYPE: imm = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                                   instr.s_fmt.imm_4_0};
            rv_pkg::B_TYPE: imm = {{19{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5[6],
                                   instr.s_fmt.imm_4_0[0], instr.s_fmt.imm_11_5[5:0],
                                   instr.s_fmt.imm_4_0[4:1], 1'b0}; // Rearranged S layout
            rv_pkg::U_TYPE: imm = {instr.u_fmt.imm_31_12, 12'b0};
            rv_pkg::J_TYPE: imm = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20,
                                   instr.j_fmt.imm_19_12, instr.j_fmt.imm_11,
                                   instr.j_fmt.imm_10_1, 1'b0};
            default:        imm = '0;              // R-type and bad opcodes carry none
        endcase
    end

endmodule

`default_nettype wire

//--- control/control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  wire [6:0]                opcode,
    input  wire [2:0]                funct3,
    input  wire [6:0]                funct7,
    input  wire rv_pkg::instr_type_t instruction_type,
    input  wire                      forward_exe_mux1,  // rs1 hits execute stage
    input  wire                      forward_exe_mux2,  // rs2 hits execute stage
    input  wire                      forward_mem_mux1,  // rs1 hits memory stage
    input  wire                      forward_mem_mux2,  // rs2 hits memory stage
    output rv_pkg::src_a_t           mux1_select,
    output rv_pkg::src_b_t           mux2_select,
    output rv_pkg::alu_op_t          alu_op,
    output logic                     read_enable_1,
    output logic                     read_enable_2,
    output logic                     write_enable
);

    rv_pkg::src_a_t a_fwd;                         // rs1 source after forwarding
    rv_pkg::src_b_t b_fwd;                         // rs2 source after forwarding
    logic           is_reg;

    assign is_reg = (opcode == rv_pkg::OP_REG);

    assign a_fwd = forward_exe_mux1 ? rv_pkg::A_FWD_EXE :
                   forward_mem_mux1 ? rv_pkg::A_FWD_MEM : rv_pkg::A_RS1;
    assign b_fwd = forward_exe_mux2 ? rv_pkg::B_FWD_EXE :
                   forward_mem_mux2 ? rv_pkg::B_FWD_MEM : rv_pkg::B_RS2;

    always_comb begin
        read_enable_1 = 1'b0;                      // BAD_TYPE leaves all low
        read_enable_2 = 1'b0;
        write_enable  = 1'b0;
        case (instruction_type)
            rv_pkg::I_TYPE: {read_enable_1, read_enable_2, write_enable} = 3'b101;
            rv_pkg::B_TYPE: {read_enable_1, read_enable_2, write_enable} = 3'b110;
            rv_pkg::S_TYPE: {read_enable_1, read_enable_2, write_enable} = 3'b110;
            rv_pkg::U_TYPE: {read_enable_1, read_enable_2, write_enable} = 3'b001;
            rv_pkg::J_TYPE: {read_enable_1, read_enable_2, write_enable} = 3'b001;
            rv_pkg::R_TYPE: {read_enable_1, read_enable_2, write_enable} = 3'b111;
            default: ;
        endcase
    end

    always_comb begin
        mux1_select = rv_pkg::A_RS1;
        mux2_select = rv_pkg::B_RS2;
        case (opcode)
            rv_pkg::OP_REG: begin
                mux1_select = a_fwd;
                mux2_select = b_fwd;
            end
            rv_pkg::OP_IMM: begin
                mux1_select = a_fwd;               // rs2 field is immediate here
                mux2_select = rv_pkg::B_IMM;
            end
            rv_pkg::OP_LUI:   mux2_select = rv_pkg::B_IMM;
            rv_pkg::OP_AUIPC: begin
                mux1_select = rv_pkg::A_PC;
                mux2_select = rv_pkg::B_IMM;
            end
            rv_pkg::OP_JAL, rv_pkg::OP_JALR: begin
                mux1_select = rv_pkg::A_PC;        // Link value PC + 4
                mux2_select = rv_pkg::B_FOUR;
            end
            default: ;
        endcase
    end

    always_comb begin
        alu_op = rv_pkg::ADD;                      // AUIPC and links add
        if (opcode == rv_pkg::OP_LUI) begin
            alu_op = rv_pkg::PASS_B;
        end else if (is_reg || opcode == rv_pkg::OP_IMM) begin
            case (funct3)
                3'b000:  alu_op = (is_reg && funct7[5]) ? rv_pkg::SUB : rv_pkg::ADD;
                3'b001:  alu_op = rv_pkg::SLL;
                3'b010:  alu_op = rv_pkg::SLT;
                3'b011:  alu_op = rv_pkg::SLTU;
                3'b100:  alu_op = rv_pkg::XOR;
                3'b101:  alu_op = funct7[5] ? rv_pkg::SRA : rv_pkg::SRL; // imm[10] for SRAI
                3'b110:  alu_op = rv_pkg::OR;
                default: alu_op = rv_pkg::AND;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- control/forward_unit.sv
`timescale 1ns/100ps
`default_nettype none

module forward_unit (
    input  wire rv_pkg::reg_idx_t rs1,
    input  wire rv_pkg::reg_idx_t rs2,
    input  wire rv_pkg::reg_idx_t exe_rd,
    input  wire rv_pkg::reg_idx_t mem_rd,
    input  wire                   exe_wr,          // ID/EX valid and writing
    input  wire                   mem_wr,          // EX/MEM valid and writing
    output logic                  forward_exe_mux1,
    output logic                  forward_exe_mux2,
    output logic                  forward_mem_mux1,
    output logic                  forward_mem_mux2
);

    logic rs1_live;
    logic rs2_live;

    assign rs1_live = (rs1 != '0);                 // x0 never forwarded
    assign rs2_live = (rs2 != '0);

    assign forward_exe_mux1 = exe_wr && rs1_live && (rs1 == exe_rd);
    assign forward_exe_mux2 = exe_wr && rs2_live && (rs2 == exe_rd);

    // Newer value in execute stage wins
    assign forward_mem_mux1 = mem_wr && rs1_live && (rs1 == mem_rd) && !forward_exe_mux1;
    assign forward_mem_mux2 = mem_wr && rs2_live && (rs2 == mem_rd) && !forward_exe_mux2;

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   read_enable_1,
    input  wire                   read_enable_2,
    input  wire rv_pkg::reg_idx_t raddr1,
    input  wire rv_pkg::reg_idx_t raddr2,
    input  wire                   write_enable,
    input  wire rv_pkg::reg_idx_t waddr,
    input  wire rv_pkg::xlen_t    wdata,
    output rv_pkg::xlen_t         rdata1,
    output rv_pkg::xlen_t         rdata2
);

    rv_pkg::xlen_t regs [32];
    logic          wr_live;

    assign wr_live = write_enable && (waddr != '0); // x0 stays zero

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr] <= wdata;
        end
    end

    // Same-cycle write seen by the reader
    assign rdata1 = !read_enable_1                   ? '0    :
                    (wr_live && waddr == raddr1)     ? wdata : regs[raddr1];
    assign rdata2 = !read_enable_2                   ? '0    :
                    (wr_live && waddr == raddr2)     ? wdata : regs[raddr2];

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire rv_pkg::alu_op_t op,
    input  wire rv_pkg::xlen_t   a,
    input  wire rv_pkg::xlen_t   b,
    output rv_pkg::xlen_t        y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];                         // Upper bits ignored for shifts

    always_comb begin
        case (op)
            rv_pkg::ADD:    y = a + b;
            rv_pkg::SUB:    y = a - b;
            rv_pkg::SLL:    y = a << shamt;
            rv_pkg::SLT:    y = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::SLTU:   y = {31'b0, a < b};
            rv_pkg::XOR:    y = a ^ b;
            rv_pkg::SRL:    y = a >> shamt;
            rv_pkg::SRA:    y = $signed(a) >>> shamt; // Sign fill
            rv_pkg::OR:     y = a | b;
            rv_pkg::AND:    y = a & b;
            rv_pkg::PASS_B: y = b;
            default:        y = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/exec_core.sv
`timescale 1ns/100ps
`default_nettype none

module exec_core (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   in_valid,
    output logic                  in_ready,
    input  wire rv_pkg::instr_u   in_instr,
    input  wire rv_pkg::xlen_t    in_pc,
    output logic                  wb_valid,
    input  wire                   wb_ready,
    output rv_pkg::reg_idx_t      wb_rd,
    output rv_pkg::xlen_t         wb_data
);

    logic [6:0]          dec_opcode;
    logic [2:0]          dec_funct3;
    logic [6:0]          dec_funct7;
    rv_pkg::reg_idx_t    dec_rs1;
    rv_pkg::reg_idx_t    dec_rs2;
    rv_pkg::reg_idx_t    dec_rd;
    rv_pkg::instr_type_t dec_type;
    rv_pkg::xlen_t       dec_imm;

    logic                fwd_exe1, fwd_exe2, fwd_mem1, fwd_mem2;
    rv_pkg::src_a_t      sel_a;
    rv_pkg::src_b_t      sel_b;
    rv_pkg::alu_op_t     ctl_op;
    logic                re1, re2, ctl_we;
    rv_pkg::xlen_t       rdata1, rdata2;
    rv_pkg::xlen_t       opnd_a, opnd_b;
    rv_pkg::xlen_t       alu_y;

    logic                idex_valid, idex_wr;  // Stage valid bits and write flags
    rv_pkg::reg_idx_t    idex_rd;
    rv_pkg::alu_op_t     idex_op;
    rv_pkg::xlen_t       idex_a, idex_b;
    logic                exmem_valid, exmem_wr;
    rv_pkg::reg_idx_t    exmem_rd;
    rv_pkg::xlen_t       exmem_result;
    logic                advance;
    logic                rf_we;

    assign advance  = !wb_valid || wb_ready;   // Whole pipe moves or holds
    assign in_ready = advance;
    assign rf_we    = advance && exmem_valid && exmem_wr; // Commit on entry to MEM/WB

    instr_decoder u_dec (
        .instr(in_instr), .opcode(dec_opcode), .funct3(dec_funct3), .funct7(dec_funct7),
        .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .instruction_type(dec_type),
        .imm(dec_imm)
    );

    forward_unit u_fwd (
        .rs1(dec_rs1), .rs2(dec_rs2), .exe_rd(idex_rd), .mem_rd(exmem_rd),
        .exe_wr(idex_valid && idex_wr), .mem_wr(exmem_valid && exmem_wr),
        .forward_exe_mux1(fwd_exe1), .forward_exe_mux2(fwd_exe2),
        .forward_mem_mux1(fwd_mem1), .forward_mem_mux2(fwd_mem2)
    );

    control_unit u_ctl (
        .opcode(dec_opcode), .funct3(dec_funct3), .funct7(dec_funct7),
        .instruction_type(dec_type),
        .forward_exe_mux1(fwd_exe1), .forward_exe_mux2(fwd_exe2),
        .forward_mem_mux1(fwd_mem1), .forward_mem_mux2(fwd_mem2),
        .mux1_select(sel_a), .mux2_select(sel_b), .alu_op(ctl_op),
        .read_enable_1(re1), .read_enable_2(re2), .write_enable(ctl_we)
    );

    reg_file u_rf (
        .clk(clk), .rst_n(rst_n), .read_enable_1(re1), .read_enable_2(re2),
        .raddr1(dec_rs1), .raddr2(dec_rs2), .write_enable(rf_we), .waddr(exmem_rd),
        .wdata(exmem_result), .rdata1(rdata1), .rdata2(rdata2)
    );

    alu u_alu (.op(idex_op), .a(idex_a), .b(idex_b), .y(alu_y));

    always_comb begin
        case (sel_a)
            rv_pkg::A_FWD_EXE: opnd_a = alu_y;     // Result of the instruction just ahead
            rv_pkg::A_PC:      opnd_a = in_pc;
            rv_pkg::A_FWD_MEM: opnd_a = exmem_result;
            default:           opnd_a = rdata1;
        endcase
        case (sel_b)
            rv_pkg::B_RS2:     opnd_b = rdata2;
            rv_pkg::B_FWD_EXE: opnd_b = alu_y;
            rv_pkg::B_IMM:     opnd_b = dec_imm;
            rv_pkg::B_FOUR:    opnd_b = 32'd4;
            rv_pkg::B_FWD_MEM: opnd_b = exmem_result;
            default:           opnd_b = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idex_valid  <= 1'b0;
            idex_wr     <= 1'b0;
            exmem_valid <= 1'b0;
            exmem_wr    <= 1'b0;
            wb_valid    <= 1'b0;
        end else if (advance) begin
            idex_valid  <= in_valid;               // in_ready is high here
            idex_wr     <= ctl_we && (dec_rd != '0); // x0 and bad opcodes stay silent
            exmem_valid <= idex_valid;
            exmem_wr    <= idex_wr;
            wb_valid    <= exmem_valid && exmem_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            idex_rd      <= dec_rd;
            idex_op      <= ctl_op;
            idex_a       <= opnd_a;                // Operands frozen at issue
            idex_b       <= opnd_b;
            exmem_rd     <= idex_rd;
            exmem_result <= alu_y;
            wb_rd        <= exmem_rd;
            wb_data      <= exmem_result;
        end
    end

endmodule

`default_nettype wire

//--- sim/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                     // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);                 // Two cycles in reset
        #1 rst_n = 1'b1;                           // Release away from the edge
    end

endmodule

`default_nettype wire

//--- sim/exec_core_props.sv
`timescale 1ns/100ps
`default_nettype none

module exec_core_props (
    input wire                   clk,
    input wire                   rst_n,
    input wire                   in_ready,
    input wire                   wb_valid,
    input wire                   wb_ready,
    input wire rv_pkg::reg_idx_t wb_rd,
    input wire rv_pkg::xlen_t    wb_data
);

    int fail_count = 0;                            // Failed assertion count

    // Offered result frozen until taken
    property wb_hold_p;
        @(posedge clk) disable iff (!rst_n)
            (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb_rd) && $stable(wb_data));
    endproperty

    property reset_idle_p;
        @(posedge clk) !rst_n |-> (!wb_valid && in_ready);
    endproperty

    property first_after_reset_p;
        @(posedge clk) $rose(rst_n) |->
            !wb_valid ##1 !wb_valid ##1 !wb_valid; // All three stages start empty
    endproperty

    property ready_rule_p;
        @(posedge clk) disable iff (!rst_n) in_ready == (!wb_valid || wb_ready);
    endproperty

    wb_hold_a: assert property (wb_hold_p) else begin
        $error("writeback output changed while wb_ready was low");
        fail_count++;
    end

    reset_idle_a: assert property (reset_idle_p) else begin
        $error("wb_valid high or in_ready low during reset");
        fail_count++;
    end

    first_after_reset_a: assert property (first_after_reset_p) else begin
        $error("wb_valid high before the pipe could fill after reset");
        fail_count++;
    end

    ready_rule_a: assert property (ready_rule_p) else begin
        $error("in_ready does not follow the advance rule");
        fail_count++;
    end

endmodule

bind exec_core exec_core_props u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_ready (in_ready),
    .wb_valid (wb_valid),
    .wb_ready (wb_ready),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
);

`default_nettype wire

//--- sim/tb_exec_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_exec_core;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic             in_ready;
    rv_pkg::instr_u   in_instr;
    rv_pkg::xlen_t    in_pc;
    logic             wb_valid;
    logic             wb_ready;
    rv_pkg::reg_idx_t wb_rd;
    rv_pkg::xlen_t    wb_data;

    rv_pkg::instr_u   tbl_instr [24];              // Stimulus table
    rv_pkg::xlen_t    tbl_pc    [24];
    bit               tbl_prod  [24];              // Row yields a writeback
    rv_pkg::reg_idx_t tbl_rd    [24];
    rv_pkg::xlen_t    tbl_data  [24];
    int               n_rows;
    int               n_expected;

    rv_pkg::reg_idx_t exp_rd_q   [$];              // Filled at acceptance
    rv_pkg::xlen_t    exp_data_q [$];
    time              accept_time;                 // First row taken here

    clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    exec_core dut (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
        .in_instr(in_instr), .in_pc(in_pc), .wb_valid(wb_valid), .wb_ready(wb_ready),
        .wb_rd(wb_rd), .wb_data(wb_data)
    );

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_rd(input rv_pkg::reg_idx_t got, input rv_pkg::reg_idx_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH wb_rd got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_data(input rv_pkg::xlen_t got, input rv_pkg::xlen_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH wb_data got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            stop_on_error($sformatf("MISMATCH wb_valid latency got 0x%h expected 0x%h",
                                    got, exp));
        end
    endtask

    // RV32I encodings straight from the ISA layouts
    function automatic logic [31:0] r_word(input logic [6:0] f7, input rv_pkg::reg_idx_t rs2,
                                           input rv_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                           input rv_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input rv_pkg::reg_idx_t rs1,
                                           input logic [2:0] f3, input rv_pkg::reg_idx_t rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input rv_pkg::reg_idx_t rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm, input rv_pkg::reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
    endfunction

    task automatic add_row(input logic [31:0] word, input bit prod,
                           input rv_pkg::reg_idx_t rd, input rv_pkg::xlen_t data);
        tbl_instr[n_rows] = word;
        tbl_pc[n_rows]    = 32'h100 + 32'(n_rows * 4); // Sequential PCs from 0x100
        tbl_prod[n_rows]  = prod;
        tbl_rd[n_rows]    = rd;
        tbl_data[n_rows]  = data;
        if (prod) begin
            n_expected++;
        end
        n_rows++;
    endtask

    task automatic build_table();
        n_rows     = 0;
        n_expected = 0;
        add_row(i_word(12'h005, 5'd0, 3'b000, 5'd1, rv_pkg::OP_IMM), 1'b1, 5'd1, 32'h5);
        add_row(i_word(12'hFFD, 5'd0, 3'b000, 5'd2, rv_pkg::OP_IMM), 1'b1, 5'd2, 32'hFFFF_FFFD);
        add_row(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1, 5'd3, 32'h2); // x2 EX, x1 MEM
        add_row(r_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 1'b1, 5'd4, 32'h8); // SUB
        add_row(r_word(7'h00, 5'd1, 5'd2, 3'b010, 5'd5), 1'b1, 5'd5, 32'h1); // SLT signed
        add_row(r_word(7'h00, 5'd1, 5'd2, 3'b011, 5'd6), 1'b1, 5'd6, 32'h0); // SLTU
        add_row(i_word(12'h401, 5'd2, 3'b101, 5'd7, rv_pkg::OP_IMM), 1'b1, 5'd7, 32'hFFFF_FFFE);
        add_row(i_word(12'h004, 5'd2, 3'b101, 5'd8, rv_pkg::OP_IMM), 1'b1, 5'd8, 32'h0FFF_FFFF);
        add_row(i_word(12'h003, 5'd1, 3'b001, 5'd9, rv_pkg::OP_IMM), 1'b1, 5'd9, 32'h28);
        add_row(i_word(12'h0FF, 5'd1, 3'b100, 5'd10, rv_pkg::OP_IMM), 1'b1, 5'd10, 32'hFA);
        add_row(u_word(20'h12345, 5'd11, rv_pkg::OP_LUI), 1'b1, 5'd11, 32'h1234_5000);
        // Immediate bit 10 set, still ADDI
        add_row(i_word(12'h678, 5'd11, 3'b000, 5'd11, rv_pkg::OP_IMM), 1'b1, 5'd11, 32'h1234_5678);
        add_row(u_word(20'h00001, 5'd12, rv_pkg::OP_AUIPC), 1'b1, 5'd12, 32'h1130); // PC 0x130
        add_row(j_word(21'd8, 5'd13), 1'b1, 5'd13, 32'h138);                   // Link from 0x134
        add_row(i_word(12'h000, 5'd1, 3'b000, 5'd14, rv_pkg::OP_JALR), 1'b1, 5'd14, 32'h13C);
        add_row(i_word(12'h007, 5'd1, 3'b000, 5'd0, rv_pkg::OP_IMM), 1'b0, 5'd0, 32'h0); // x0
        add_row(r_word(7'h00, 5'd1, 5'd0, 3'b000, 5'd15), 1'b1, 5'd15, 32'h5); // x0 reads 0
        add_row(i_word(12'h000, 5'd0, 3'b010, 5'd1, 7'b0000011), 1'b0, 5'd0, 32'h0); // Load
        add_row(i_word(12'h001, 5'd1, 3'b000, 5'd16, rv_pkg::OP_IMM), 1'b1, 5'd16, 32'h6);
        add_row(r_word(7'h00, 5'd4, 5'd16, 3'b110, 5'd17), 1'b1, 5'd17, 32'hE); // OR
        add_row(i_word(12'h064, 5'd0, 3'b000, 5'd19, rv_pkg::OP_IMM), 1'b1, 5'd19, 32'h64);
        add_row(i_word(12'h001, 5'd19, 3'b000, 5'd19, rv_pkg::OP_IMM), 1'b1, 5'd19, 32'h65);
        add_row(r_word(7'h00, 5'd19, 5'd19, 3'b000, 5'd20), 1'b1, 5'd20, 32'hCA); // EX wins
        add_row(r_word(7'h00, 5'd17, 5'd20, 3'b111, 5'd21), 1'b1, 5'd21, 32'hA);  // AND
    endtask

    task automatic feed_rows();
        bit taken;
        @(posedge clk);
        #1;
        for (int i = 0; i < n_rows; i++) begin
            in_valid = 1'b1;
            in_instr = tbl_instr[i];
            in_pc    = tbl_pc[i];
            taken    = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = in_ready;                  // Transfer on the coming edge
                if (taken && i == 0) begin
                    accept_time = $time;
                end
                @(posedge clk);
                #1;
            end
            if (tbl_prod[i]) begin
                exp_rd_q.push_back(tbl_rd[i]);
                exp_data_q.push_back(tbl_data[i]);
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_results();
        int               got;
        bit               seen_first;
        rv_pkg::reg_idx_t exp_rd;
        rv_pkg::xlen_t    exp_data;
        got        = 0;
        seen_first = 1'b0;
        while (got < n_expected) begin
            @(negedge clk);
            check_flag("in_ready", in_ready, !wb_valid || wb_ready); // Stall rule
            if (wb_valid && !seen_first) begin
                seen_first = 1'b1;
                check_latency(int'(($time - accept_time) / 4), 3);
            end
            if (wb_valid && wb_ready) begin
                if (exp_rd_q.size() == 0) begin
                    stop_on_error("writeback arrived while no result was expected");
                end
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                check_rd(wb_rd, exp_rd);
                check_data(wb_data, exp_data);
                got++;
            end
        end
    endtask

    initial begin
        void'($urandom(9657));
        wb_ready = 1'b1;                           // High through the latency check
        repeat (12) @(posedge clk);
        forever begin
            @(posedge clk);
            #1;
            wb_ready = ($urandom % 4) != 0;        // About one stall cycle in four
        end
    end

    initial begin
        #(24 * 10 * 4 + 8);                        // Rows x 10 cycles x period, plus reset
        stop_on_error("timeout: the pipeline did not deliver every result in time");
    end

    initial begin
        in_valid = 1'b0;
        in_instr = '0;
        in_pc    = '0;
        build_table();
        @(posedge rst_n);
        @(negedge clk);
        check_flag("wb_valid", wb_valid, 1'b0);    // Empty after reset
        check_flag("in_ready", in_ready, 1'b1);
        fork
            feed_rows();
            collect_results();
        join
        repeat (8) begin
            @(negedge clk);
            if (wb_valid) begin
                stop_on_error("writeback seen after the last expected result");
            end
        end
        if (dut.u_props.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            stop_on_error("an assertion on the DUT handshakes failed during the run");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
common/rv_pkg.sv
hdl/instr_decoder.sv
control/control_unit.sv
control/forward_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/exec_core.sv
sim/clk_gen.sv
sim/exec_core_props.sv
sim/tb_exec_core.sv

//--- run.sh
#!/bin/sh
# Compile and run the exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_exec_core -Mdir obj_dir -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_exec_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
